// File: rtl/message_reporter.sv
`timescale 1ns/1ps

module message_reporter import terminal_pkg::*; (
        input  logic  clk,
        input  logic  rst_n,
        input  logic  init_req,
        input  logic  cpu_mode_req,
        input  logic  alu_mode_req,
        input  logic  advance,
        output logic  pending,
        output byte_t out_byte,
        output logic  last
);

        localparam int POS_W    = $clog2(MSG_MAX_LEN);
        localparam int INIT_LEN = $bits(INIT_TEXT) / 8;
        localparam int CPU_LEN  = $bits(CPU_MODE_TEXT) / 8;
        localparam int ALU_LEN  = $bits(ALU_MODE_TEXT) / 8;

        logic             pend_init_q;
        logic             pend_cpu_q;
        logic             pend_alu_q;
        logic [POS_W-1:0] pos_q;
        msg_id_t          cur_q;
        msg_id_t          sel;

        assign pending = pend_init_q | pend_cpu_q | pend_alu_q;

        // Pick a new message only between messages
        always_comb begin
                if (pos_q != '0) begin
                        sel = cur_q;
                end else if (pend_init_q) begin
                        sel = msg_init;
                end else if (pend_cpu_q) begin
                        sel = msg_cpu_mode;
                end else begin
                        sel = msg_alu_mode;
                end
        end

        ////////////////////////////////////////////////////////////////////////////
        // Character fetch
        ////////////////////////////////////////////////////////////////////////////

        always_comb begin
                case (sel)
                        msg_init: begin
                                out_byte = INIT_TEXT[8*(INIT_LEN-1-int'(pos_q)) +: 8];
                                last     = (pos_q == POS_W'(INIT_LEN - 1));
                        end
                        msg_cpu_mode: begin
                                out_byte = CPU_MODE_TEXT[8*(CPU_LEN-1-int'(pos_q)) +: 8];
                                last     = (pos_q == POS_W'(CPU_LEN - 1));
                        end
                        default: begin
                                out_byte = ALU_MODE_TEXT[8*(ALU_LEN-1-int'(pos_q)) +: 8];
                                last     = (pos_q == POS_W'(ALU_LEN - 1));
                        end
                endcase
        end

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        pend_init_q <= 1'b0;
                        pend_cpu_q  <= 1'b0;
                        pend_alu_q  <= 1'b0;
                        pos_q       <= '0;
                        cur_q       <= msg_init;
                end else begin
                        if (advance) begin
                                cur_q <= sel;
                                if (last) begin
                                        pos_q <= '0;
                                        case (sel)
                                                msg_init:     pend_init_q <= 1'b0;
                                                msg_cpu_mode: pend_cpu_q  <= 1'b0;
                                                default:      pend_alu_q  <= 1'b0;
                                        endcase
                                end else begin
                                        pos_q <= pos_q + 1'b1;
                                end
                        end
                        // New requests win over the clear
                        if (init_req) pend_init_q <= 1'b1;
                        if (cpu_mode_req) pend_cpu_q <= 1'b1;
                        if (alu_mode_req) pend_alu_q <= 1'b1;
                end
        end

endmodule

// File: rtl/terminal_arbiter.sv
`timescale 1ns/1ps

module terminal_arbiter import terminal_pkg::*; (
        input  logic  clk,
        input  logic  rst_n,
        input  logic  slot,
        input  logic  tx_busy,
        input  logic  newline_req,
        input  logic  kb_done,
        input  byte_t key_data,
        input  logic  pc_pending,
        input  logic  pc_last,
        input  logic  alu_pending,
        input  logic  alu_last,
        input  logic  msg_pending,
        input  logic  msg_last,
        input  byte_t pc_byte,
        input  byte_t alu_byte,
        input  byte_t msg_byte,
        output logic  pc_advance,
        output logic  alu_advance,
        output logic  msg_advance,
        output logic  tx_start,
        output byte_t tx_data
);

        typedef enum logic [2:0] {
                own_none,
                own_pc,
                own_alu,
                own_msg,
                own_nl,
                own_kb
        } owner_t;

        owner_t owner_q;
        owner_t cur_owner;
        logic   slot_open;
        logic   nl_pend;
        logic   kb_pend;
        byte_t  key_q;
        byte_t  cur_byte;
        logic   cur_last;
        logic   issue;

        ////////////////////////////////////////////////////////////////////////////
        // Owner selection, held until the last byte of a sequence
        ////////////////////////////////////////////////////////////////////////////

        always_comb begin
                cur_owner = owner_q;
                if (owner_q == own_none) begin
                        if (pc_pending)        cur_owner = own_pc;
                        else if (alu_pending)  cur_owner = own_alu;
                        else if (msg_pending)  cur_owner = own_msg;
                        else if (nl_pend)      cur_owner = own_nl;
                        else if (kb_pend)      cur_owner = own_kb;
                end
        end

        always_comb begin
                cur_byte = CHAR_LF;
                cur_last = 1'b1;   // Newline and key are single bytes
                case (cur_owner)
                        own_pc: begin
                                cur_byte = pc_byte;
                                cur_last = pc_last;
                        end
                        own_alu: begin
                                cur_byte = alu_byte;
                                cur_last = alu_last;
                        end
                        own_msg: begin
                                cur_byte = msg_byte;
                                cur_last = msg_last;
                        end
                        own_kb:  cur_byte = key_q;
                        default: cur_byte = CHAR_LF;
                endcase
        end

        assign issue       = slot_open && !tx_busy && (cur_owner != own_none);
        assign pc_advance  = issue && (cur_owner == own_pc);
        assign alu_advance = issue && (cur_owner == own_alu);
        assign msg_advance = issue && (cur_owner == own_msg);

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        owner_q   <= own_none;
                        slot_open <= 1'b0;
                        nl_pend   <= 1'b0;
                        kb_pend   <= 1'b0;
                        tx_start  <= 1'b0;
                end else begin
                        tx_start <= issue;
                        if (slot) slot_open <= 1'b1;
                        if (issue) begin
                                owner_q   <= cur_last ? own_none : cur_owner;
                                slot_open <= 1'b0;   // A slot arriving now is dropped
                                if (cur_owner == own_nl) nl_pend <= 1'b0;
                                if (cur_owner == own_kb) kb_pend <= 1'b0;
                        end
                        if (newline_req) nl_pend <= 1'b1;
                        if (kb_done) kb_pend <= 1'b1;
                end
        end

        always_ff @(posedge clk) begin
                if (issue) tx_data <= cur_byte;
                if (kb_done) key_q <= key_data;
        end

endmodule

// File: rtl/terminal_pkg.sv
package terminal_pkg;

        typedef logic [7:0] byte_t;

        typedef enum logic [1:0] {
                msg_init,
                msg_cpu_mode,
                msg_alu_mode
        } msg_id_t;

        // Start bit, eight data bits, stop bit
        localparam int FRAME_TICKS = 10;

        // Longest message, sizes the position counter
        localparam int MSG_MAX_LEN = 60;

        localparam byte_t CHAR_CR = 8'd13;
        localparam byte_t CHAR_LF = 8'd10;

        ////////////////////////////////////////////////////////////////////////////
        // Message text, first character in the top byte
        ////////////////////////////////////////////////////////////////////////////

        localparam logic [8*60-1:0] INIT_TEXT =
                "Hello EC551. My name is Minterminal. Please choose a mode:\r\n";

        localparam logic [8*30-1:0] CPU_MODE_TEXT = "Mode I: Instruction Entry   \r\n";

        localparam logic [8*30-1:0] ALU_MODE_TEXT = "Mode A: ALU Function        \r\n";

endpackage

// File: rtl/terminal_tx_mux.sv
`timescale 1ns/1ps

module terminal_tx_mux import terminal_pkg::*; #(
        parameter int CLK_FREQ_HZ = 100_000_000,
        parameter int BAUD_RATE   = 9600,
        parameter int PC_W        = 64,
        parameter int ALU_W       = 24
) (
        input  logic             clk,
        input  logic             rst_n,
        input  logic             pc_req,
        input  logic             alu_req,
        input  logic             init_req,
        input  logic             cpu_mode_req,
        input  logic             alu_mode_req,
        input  logic             newline_req,
        input  logic             kb_done,
        input  logic [PC_W-1:0]  pc,
        input  logic [ALU_W-1:0] alu_result,
        input  byte_t            key_data,
        input  logic             tx_busy,
        output logic             tx_start,
        output byte_t            tx_data
);

        logic  slot;
        logic  pc_pending, pc_last, pc_advance;
        logic  alu_pending, alu_last, alu_advance;
        logic  msg_pending, msg_last, msg_advance;
        byte_t pc_byte;
        byte_t alu_byte;
        byte_t msg_byte;

        tx_pacer #(
                .CLK_FREQ_HZ (CLK_FREQ_HZ),
                .BAUD_RATE   (BAUD_RATE)
        ) pacer (
                .clk   (clk),
                .rst_n (rst_n),
                .slot  (slot)
        );

        ////////////////////////////////////////////////////////////////////////////
        // Byte sources
        ////////////////////////////////////////////////////////////////////////////

        value_reporter #(.payload_t(logic [PC_W-1:0])) pc_reporter (
                .clk      (clk),
                .rst_n    (rst_n),
                .req      (pc_req),
                .value    (pc),
                .advance  (pc_advance),
                .pending  (pc_pending),
                .out_byte (pc_byte),
                .last     (pc_last)
        );

        value_reporter #(.payload_t(logic [ALU_W-1:0])) alu_reporter (
                .clk      (clk),
                .rst_n    (rst_n),
                .req      (alu_req),
                .value    (alu_result),
                .advance  (alu_advance),
                .pending  (alu_pending),
                .out_byte (alu_byte),
                .last     (alu_last)
        );

        message_reporter msg_reporter (
                .clk          (clk),
                .rst_n        (rst_n),
                .init_req     (init_req),
                .cpu_mode_req (cpu_mode_req),
                .alu_mode_req (alu_mode_req),
                .advance      (msg_advance),
                .pending      (msg_pending),
                .out_byte     (msg_byte),
                .last         (msg_last)
        );

        terminal_arbiter arbiter (
                .clk (clk), .rst_n (rst_n), .slot (slot), .tx_busy (tx_busy),
                .newline_req (newline_req), .kb_done (kb_done), .key_data (key_data),
                .pc_pending (pc_pending), .pc_last (pc_last),
                .alu_pending (alu_pending), .alu_last (alu_last),
                .msg_pending (msg_pending), .msg_last (msg_last),
                .pc_byte (pc_byte), .alu_byte (alu_byte), .msg_byte (msg_byte),
                .pc_advance (pc_advance), .alu_advance (alu_advance),
                .msg_advance (msg_advance), .tx_start (tx_start), .tx_data (tx_data)
        );

endmodule

// File: rtl/tx_pacer.sv
`timescale 1ns/1ps

module tx_pacer import terminal_pkg::*; #(
        parameter int CLK_FREQ_HZ = 100_000_000,
        parameter int BAUD_RATE   = 9600
) (
        input  logic clk,
        input  logic rst_n,
        output logic slot
);

        localparam int ACC_W   = $clog2(CLK_FREQ_HZ + BAUD_RATE);
        localparam int FRAME_W = $clog2(FRAME_TICKS);

        logic [ACC_W-1:0]   acc_q;
        logic [ACC_W-1:0]   acc_sum;
        logic               baud_tick;
        logic [FRAME_W-1:0] frame_cnt_q;

        // Phase accumulator, wraps at the clock rate
        assign acc_sum   = acc_q + ACC_W'(BAUD_RATE);
        assign baud_tick = (acc_sum >= ACC_W'(CLK_FREQ_HZ));

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        acc_q       <= '0;
                        frame_cnt_q <= '0;
                        slot        <= 1'b0;
                end else begin
                        slot <= 1'b0;
                        if (baud_tick) begin
                                acc_q <= acc_sum - ACC_W'(CLK_FREQ_HZ);
                                if (frame_cnt_q == FRAME_W'(FRAME_TICKS - 1)) begin
                                        frame_cnt_q <= '0;
                                        slot        <= 1'b1;   // One byte per frame
                                end else begin
                                        frame_cnt_q <= frame_cnt_q + 1'b1;
                                end
                        end else begin
                                acc_q <= acc_sum;
                        end
                end
        end

endmodule

// File: rtl/value_reporter.sv
`timescale 1ns/1ps

module value_reporter import terminal_pkg::*; #(
        parameter type payload_t = logic [15:0]
) (
        input  logic     clk,
        input  logic     rst_n,
        input  logic     req,
        input  payload_t value,
        input  logic     advance,
        output logic     pending,
        output byte_t    out_byte,
        output logic     last
);

        localparam int PAYLOAD_W = $bits(payload_t);
        localparam int NBYTES    = PAYLOAD_W / 8;
        localparam int IDX_W     = $clog2(NBYTES + 2);

        logic [PAYLOAD_W-1:0] shift_q;   // Top byte is the one on offer
        logic [IDX_W-1:0]     idx_q;

        ////////////////////////////////////////////////////////////////////////////
        // Byte sequence control
        ////////////////////////////////////////////////////////////////////////////

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        pending <= 1'b0;
                        idx_q   <= '0;
                end else if (req) begin
                        pending <= 1'b1;
                        idx_q   <= '0;
                end else if (advance) begin
                        if (last) begin
                                pending <= 1'b0;
                                idx_q   <= '0;
                        end else begin
                                idx_q <= idx_q + 1'b1;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (req) begin
                        shift_q <= value;
                end else if (advance) begin
                        shift_q <= shift_q << 8;
                end
        end

        always_comb begin
                if (idx_q < IDX_W'(NBYTES)) begin
                        out_byte = shift_q[PAYLOAD_W-1 -: 8];
                end else if (idx_q == IDX_W'(NBYTES)) begin
                        out_byte = CHAR_CR;
                end else begin
                        out_byte = CHAR_LF;
                end
        end

        assign last = (idx_q == IDX_W'(NBYTES + 1));   // LF closes the report

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --top-module terminal_tx_mux_tb -f terminal_tx_mux.f &&
./obj_dir/Vterminal_tx_mux_tb | tee /dev/stderr | grep -x "ALL CHECKS PASSED" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: terminal_tx_mux.f
rtl/terminal_pkg.sv
rtl/tx_pacer.sv
rtl/value_reporter.sv
rtl/message_reporter.sv
rtl/terminal_arbiter.sv
rtl/terminal_tx_mux.sv
verification/terminal_tx_mux_tb.sv

// File: verification/terminal_tx_mux_tb.sv
`timescale 1ns/1ps

module terminal_tx_mux_tb import terminal_pkg::*; ();

        logic        clk = 1'b0;
        logic        rst_n;
        logic        pc_req;
        logic        alu_req;
        logic        init_req;
        logic        cpu_mode_req;
        logic        alu_mode_req;
        logic        newline_req;
        logic        kb_done;
        logic [63:0] pc;
        logic [23:0] alu_result;
        byte_t       key_data;
        logic        tx_busy;
        logic        tx_start;
        byte_t       tx_data;

        logic [31:0] lfsr;
        byte_t       exp_q[$];          // Bytes still owed by the DUT, oldest first
        int          busy_cnt;
        logic        start_prev;
        int          mismatch_errs;
        int          other_errs;
        int          checked;

        terminal_tx_mux #(
                .CLK_FREQ_HZ (1_000_000),
                .BAUD_RATE   (250_000),
                .PC_W        (64),
                .ALU_W       (24)
        ) UUT (
                .clk          (clk),
                .rst_n        (rst_n),
                .pc_req       (pc_req),
                .alu_req      (alu_req),
                .init_req     (init_req),
                .cpu_mode_req (cpu_mode_req),
                .alu_mode_req (alu_mode_req),
                .newline_req  (newline_req),
                .kb_done      (kb_done),
                .pc           (pc),
                .alu_result   (alu_result),
                .key_data     (key_data),
                .tx_busy      (tx_busy),
                .tx_start     (tx_start),
                .tx_data      (tx_data)
        );

        always #10 clk = ~clk;

        ////////////////////////////////////////////////////////////////////////////
        // Random source, one LFSR step per bit
        ////////////////////////////////////////////////////////////////////////////

        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                if (s[0])
                        return (s >> 1) ^ 32'h8020_0003;
                return s >> 1;
        endfunction

        task automatic draw_bits(input int n, output logic [63:0] v);
                int k;
                v = '0;
                for (k = 0; k < n; k++) begin
                        v    = {v[62:0], lfsr[0]};
                        lfsr = lfsr_next(lfsr);
                end
        endtask

        task automatic push_text(input logic [8*60-1:0] text, input int len);
                int i;
                for (i = 0; i < len; i++)
                        exp_q.push_back(text[8*(len-1-i) +: 8]);   // First char on top
        endtask

        ////////////////////////////////////////////////////////////////////////////
        // One clock: output checks, then the busy model
        ////////////////////////////////////////////////////////////////////////////

        task automatic tick();
                byte_t       exp_byte;
                logic [63:0] v;
                @(posedge clk);
                if (tx_start) begin
                        if (tx_busy) begin
                                other_errs++;
                                $display("tx_start high while tx_busy high at %0t", $time);
                        end
                        if (start_prev) begin
                                other_errs++;
                                $display("tx_start longer than one cycle at %0t", $time);
                        end
                        if (exp_q.size() == 0) begin
                                other_errs++;
                                $display("extra byte %h sent with nothing expected", tx_data);
                        end else begin
                                exp_byte = exp_q.pop_front();
                                checked++;
                                if (tx_data !== exp_byte) begin
                                        mismatch_errs++;
                                        $display("mismatch tx_data: expected %h, got %h",
                                                 exp_byte, tx_data);
                                end
                        end
                end
                start_prev = tx_start;
                if (tx_start) begin
                        draw_bits(6, v);
                        busy_cnt = int'(v[5:0]) % 61;   // 0 to 60 busy cycles
                        tx_busy <= (busy_cnt != 0);
                end else if (busy_cnt > 1) begin
                        busy_cnt--;
                end else begin
                        busy_cnt = 0;
                        tx_busy <= 1'b0;
                end
        endtask

        // Mask bits: pc, alu, init, cpu mode, alu mode, newline, key
        task automatic run_batch(input logic [6:0] mask);
                logic [63:0] pc_val;
                logic [63:0] alu_val;
                logic [63:0] key_val;
                logic [63:0] spare;
                int          i;
                int          limit;
                int          n;
                draw_bits(64, pc_val);
                draw_bits(24, alu_val);
                draw_bits(8, key_val);
                draw_bits(64, spare);
                tick();
                pc_req       <= mask[0];
                alu_req      <= mask[1];
                init_req     <= mask[2];
                cpu_mode_req <= mask[3];
                alu_mode_req <= mask[4];
                newline_req  <= mask[5];
                kb_done      <= mask[6];
                pc           <= pc_val;
                alu_result   <= alu_val[23:0];
                key_data     <= key_val[7:0];
                // Expected stream in priority order
                if (mask[0]) begin
                        for (i = 7; i >= 0; i--)
                                exp_q.push_back(pc_val[8*i +: 8]);
                        exp_q.push_back(8'd13);
                        exp_q.push_back(8'd10);
                end
                if (mask[1]) begin
                        for (i = 2; i >= 0; i--)
                                exp_q.push_back(alu_val[8*i +: 8]);
                        exp_q.push_back(8'd13);
                        exp_q.push_back(8'd10);
                end
                if (mask[2]) push_text(INIT_TEXT, 60);
                if (mask[3]) push_text(480'(CPU_MODE_TEXT), 30);
                if (mask[4]) push_text(480'(ALU_MODE_TEXT), 30);
                if (mask[5]) exp_q.push_back(8'd10);
                if (mask[6]) exp_q.push_back(key_val[7:0]);
                tick();
                pc_req       <= 1'b0;
                alu_req      <= 1'b0;
                init_req     <= 1'b0;
                cpu_mode_req <= 1'b0;
                alu_mode_req <= 1'b0;
                newline_req  <= 1'b0;
                kb_done      <= 1'b0;
                pc           <= spare;           // Captured values must not follow
                alu_result   <= spare[39:16];
                key_data     <= spare[63:56];
                limit = 150 * exp_q.size() + 400;
                n = 0;
                while (exp_q.size() != 0 && n < limit) begin
                        tick();
                        n++;
                end
                if (exp_q.size() != 0) begin
                        other_errs++;
                        $display("timeout, %0d expected bytes never sent for mask %b",
                                 exp_q.size(), mask);
                        exp_q.delete();
                end
        endtask

        initial begin
                logic [63:0] v;
                int          b;
                lfsr          = 32'h79b6;
                mismatch_errs = 0;
                other_errs    = 0;
                checked       = 0;
                busy_cnt      = 0;
                start_prev    = 1'b0;
                rst_n         <= 1'b0;
                pc_req        <= 1'b0;
                alu_req       <= 1'b0;
                init_req      <= 1'b0;
                cpu_mode_req  <= 1'b0;
                alu_mode_req  <= 1'b0;
                newline_req   <= 1'b0;
                kb_done       <= 1'b0;
                pc            <= '0;
                alu_result    <= '0;
                key_data      <= '0;
                tx_busy       <= 1'b0;
                repeat (16) tick();
                rst_n <= 1'b1;
                repeat (200) tick();   // Idle, any byte here is extra
                // Each source alone, then all at once
                run_batch(7'b0000100);
                run_batch(7'b0001000);
                run_batch(7'b0010000);
                run_batch(7'b0000001);
                run_batch(7'b0000010);
                run_batch(7'b0100000);
                run_batch(7'b1000000);
                run_batch(7'b1111111);
                for (b = 0; b < 40; b++) begin
                        draw_bits(7, v);
                        if (v[6:0] == 7'd0)
                                v[6:0] = 7'b0100000;
                        run_batch(v[6:0]);
                        draw_bits(4, v);
                        repeat (int'(v[3:0])) tick();
                end
                repeat (300) tick();   // Late extras
                $display("errors: %0d mismatches, %0d other, %0d bytes checked",
                         mismatch_errs, other_errs, checked);
                if (mismatch_errs == 0 && other_errs == 0) begin
                        $display("ALL CHECKS PASSED");
                end else begin
                        $display("CHECKS FAILED");
                end
                $finish;
        end

endmodule
